/* riscv_lite.f */
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/operand_decode.sv
hdl/execute_unit.sv
hdl/writeback_unit.sv
hdl/riscv_pipeline.sv
testbench/tb_riscv_pipeline.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run the model, and decide the result from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_riscv_pipeline -f riscv_lite.f -o tb_sim \
  || { echo "verilator build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned a nonzero status"
cat sim.log
grep -q "Something failed" sim.log && echo "simulation FAILED" && exit 1
grep -q "Everything OK" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"
exit 0

/* testbench/pipeline_stim.txt */
# P byte_address(hex) instruction(hex)
# E test status pc insn we rd data   (status 1 reset, 2 running, 4 taken-branch bubble)
# rd and data are only compared when we is 1
P 00000000 123450B7
P 00000004 06400113
P 00000008 FFB00193
P 0000000C ABCDE337
P 00000010 7FF00393
P 00000014 00208233
P 00000018 00120413
P 0000001C 008184B3
P 00000020 00740533
P 00000024 009405B3
P 00000028 00500013
P 0000002C 00600633
P 00000030 00211463
P 00000034 00160693
P 00000038 00209863
P 0000003C 00100713
P 00000040 00200793
P 00000044 00300813
P 00000048 007688B3
P 0000004C FFF88913
E 1 1 00000000 00000000 0 00 00000000
E 1 1 00000000 00000000 0 00 00000000
E 1 1 00000000 00000000 0 00 00000000
E 1 1 00000000 00000000 0 00 00000000
E 1 2 00000000 123450B7 1 01 12345000
E 2 2 00000004 06400113 1 02 00000064
E 2 2 00000008 FFB00193 1 03 FFFFFFFB
E 2 2 0000000C ABCDE337 1 06 ABCDE000
E 2 2 00000010 7FF00393 1 07 000007FF
E 2 2 00000014 00208233 1 04 12345064
E 3 2 00000018 00120413 1 08 12345065
E 3 2 0000001C 008184B3 1 09 12345060
E 3 2 00000020 00740533 1 0A 12345864
E 3 2 00000024 009405B3 1 0B 2468A0C5
E 4 2 00000028 00500013 0 00 00000000
E 4 2 0000002C 00600633 1 0C ABCDE000
E 4 2 00000030 00211463 0 00 00000000
E 4 2 00000034 00160693 1 0D ABCDE001
E 5 2 00000038 00209863 0 00 00000000
E 5 4 00000000 00000000 0 00 00000000
E 5 4 00000000 00000000 0 00 00000000
E 5 2 00000048 007688B3 1 11 ABCDE800
E 5 2 0000004C FFF88913 1 12 ABCDE7FF
E 5 2 00000050 00000013 0 00 00000000

/* testbench/tb_riscv_pipeline.sv */
`timescale 1ns/100ps

module tb_riscv_pipeline;

  localparam string stim_path = "testbench/pipeline_stim.txt";
  localparam logic [31:0] reset_pc = 32'h0000_0000;
  // addi x0, x0, 0
  localparam logic [31:0] nop_word = 32'h0000_0013;

  logic                  clk;
  logic                  rst;
  logic [31:0]           pc_to_imem;
  logic [31:0]           insn_from_imem;
  logic [31:0]           trace_pc;
  logic [31:0]           trace_insn;
  rv_pkg::cycle_status_e trace_status;
  logic                  trace_we;
  logic [4:0]            trace_rd;
  logic [31:0]           trace_data;

  // program words keyed by word address
  logic [31:0] prog_mem [int];
  // one expected trace record per cycle after reset
  logic [31:0] exp_test [$];
  logic [31:0] exp_status [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_insn [$];
  logic [31:0] exp_we [$];
  logic [31:0] exp_rd [$];
  logic [31:0] exp_data [$];

  int errors = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  riscv_pipeline #(
    .reset_pc (reset_pc)
  ) i_dut (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .trace_pc       (trace_pc),
    .trace_insn     (trace_insn),
    .trace_status   (trace_status),
    .trace_we       (trace_we),
    .trace_rd       (trace_rd),
    .trace_data     (trace_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] read_imem(input logic [31:0] addr);
    if (prog_mem.exists(int'(addr >> 2))) begin
      return prog_mem[int'(addr >> 2)];
    end
    return nop_word;
  endfunction

  // instruction memory, answers shortly after the pc has moved
  always @(posedge clk) begin
    #1;
    insn_from_imem = read_imem(pc_to_imem);
  end

  // run limit, the trace must be done well before this
  always @(posedge clk) begin
    if (!rst) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
        $display("timeout: trace checks still running after %0d cycles", cycle_limit);
        $display("Something failed");
        $finish;
      end
    end
  end

  function automatic string test_name(input logic [31:0] id);
    case (id)
      1: return "reset then first fetch";
      2: return "independent lui addi add";
      3: return "MX WX WD bypass";
      4: return "x0 write and bne not taken";
      5: return "bne taken";
      default: return "unnamed";
    endcase
  endfunction

  task automatic load_stimulus(output bit ok);
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] test_id;
    logic [31:0] status;
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] we;
    logic [31:0] rd;
    logic [31:0] data;
    ok = 1'b0;
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", stim_path);
    end else begin
      while ($fgets(line, fd) > 0) begin
        tag = line.getc(0);
        if (tag == "P") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h", pc, insn);
          if (n == 2) begin
            prog_mem[int'(pc >> 2)] = insn;
          end
        end else if (tag == "E") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                      test_id, status, pc, insn, we, rd, data);
          if (n == 7) begin
            exp_test.push_back(test_id);
            exp_status.push_back(status);
            exp_pc.push_back(pc);
            exp_insn.push_back(insn);
            exp_we.push_back(we);
            exp_rd.push_back(rd);
            exp_data.push_back(data);
          end
        end
      end
      $fclose(fd);
      ok = exp_test.size() > 0;
      if (!ok) begin
        $display("the stimulus file %s holds no trace records", stim_path);
      end
    end
  endtask

  task automatic compare_field(input int idx, input string field,
                               input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      $display("[ERROR] %0t: record %0d %s is %h, expected %h", $time, idx, field, got, want);
      errors++;
    end
  endtask

  task automatic check_record(input int idx);
    compare_field(idx, "status", 32'(trace_status), exp_status[idx]);
    compare_field(idx, "pc", trace_pc, exp_pc[idx]);
    compare_field(idx, "insn", trace_insn, exp_insn[idx]);
    compare_field(idx, "we", 32'(trace_we), exp_we[idx]);
    // rd and data carry meaning only with a register write
    if (exp_we[idx] != 0) begin
      compare_field(idx, "rd", 32'(trace_rd), exp_rd[idx]);
      compare_field(idx, "data", trace_data, exp_data[idx]);
    end
  endtask

  initial begin
    bit loaded;
    int test_records;
    int test_bad;
    int err_before;
    int num_tests;
    rst = 1'b1;
    insn_from_imem = nop_word;
    test_records = 0;
    test_bad = 0;
    num_tests = 0;
    load_stimulus(loaded);
    cycle_limit = exp_test.size() + 20;
    if (!loaded) begin
      $display("no trace records to check");
      $display("Something failed");
      $finish;
    end else begin
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      // trace is stable in the low half of the clock
      for (int i = 0; i < exp_test.size(); i++) begin
        @(negedge clk);
        err_before = errors;
        check_record(i);
        test_records++;
        if (errors != err_before) begin
          test_bad++;
        end
        if (i == exp_test.size() - 1 || exp_test[i + 1] != exp_test[i]) begin
          $display("test %0d (%s): %0d records, %0d mismatching", exp_test[i],
                   test_name(exp_test[i]), test_records, test_bad);
          num_tests++;
          test_records = 0;
          test_bad = 0;
        end
      end
      $display("%0d records in %0d tests checked, %0d field errors",
               exp_test.size(), num_tests, errors);
      if (errors == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

/* hdl/riscv_pipeline.sv */
`timescale 1ns/100ps

module riscv_pipeline #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  output logic [rv_pkg::xlen-1:0]       pc_to_imem,
  input  logic [31:0]                   insn_from_imem,
  output logic [rv_pkg::xlen-1:0]       trace_pc,
  output logic [31:0]                   trace_insn,
  output rv_pkg::cycle_status_e         trace_status,
  output logic                          trace_we,
  output logic [rv_pkg::reg_addr_w-1:0] trace_rd,
  output logic [rv_pkg::xlen-1:0]       trace_data
);

  // fetch to decode
  logic [rv_pkg::xlen-1:0]       d_pc;
  logic [31:0]                   d_insn;
  rv_pkg::cycle_status_e         d_status;
  // decode to execute
  logic [rv_pkg::xlen-1:0]       x_pc;
  logic [31:0]                   x_insn;
  logic [rv_pkg::xlen-1:0]       x_a;
  logic [rv_pkg::xlen-1:0]       x_b;
  rv_pkg::cycle_status_e         x_status;
  // branch redirect
  logic                          redirect;
  logic [rv_pkg::xlen-1:0]       redirect_pc;
  // memory to writeback
  logic [rv_pkg::xlen-1:0]       m_pc;
  logic [31:0]                   m_insn;
  logic [rv_pkg::xlen-1:0]       m_result;
  logic                          m_we;
  rv_pkg::cycle_status_e         m_status;
  // register write, also the WD and WX bypass source
  logic                          w_we;
  logic [rv_pkg::reg_addr_w-1:0] w_rd;
  logic [rv_pkg::xlen-1:0]       w_data;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) i_fetch_unit (
    .clk            (clk),
    .rst            (rst),
    .insn_from_imem (insn_from_imem),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .pc_to_imem     (pc_to_imem),
    .d_pc           (d_pc),
    .d_insn         (d_insn),
    .d_status       (d_status)
  );

  operand_decode i_operand_decode (
    .clk      (clk),
    .rst      (rst),
    .d_pc     (d_pc),
    .d_insn   (d_insn),
    .d_status (d_status),
    .redirect (redirect),
    .w_we     (w_we),
    .w_rd     (w_rd),
    .w_data   (w_data),
    .x_pc     (x_pc),
    .x_insn   (x_insn),
    .x_a      (x_a),
    .x_b      (x_b),
    .x_status (x_status)
  );

  execute_unit i_execute_unit (
    .clk         (clk),
    .rst         (rst),
    .x_pc        (x_pc),
    .x_insn      (x_insn),
    .x_a         (x_a),
    .x_b         (x_b),
    .x_status    (x_status),
    .w_we        (w_we),
    .w_rd        (w_rd),
    .w_data      (w_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .m_pc        (m_pc),
    .m_insn      (m_insn),
    .m_result    (m_result),
    .m_we        (m_we),
    .m_status    (m_status)
  );

  writeback_unit i_writeback_unit (
    .clk          (clk),
    .rst          (rst),
    .m_pc         (m_pc),
    .m_insn       (m_insn),
    .m_result     (m_result),
    .m_we         (m_we),
    .m_status     (m_status),
    .w_we         (w_we),
    .w_rd         (w_rd),
    .w_data       (w_data),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_we     (trace_we),
    .trace_rd     (trace_rd),
    .trace_data   (trace_data)
  );

endmodule

/* hdl/writeback_unit.sv */
`timescale 1ns/100ps

module writeback_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       m_pc,
  input  logic [31:0]                   m_insn,
  input  logic [rv_pkg::xlen-1:0]       m_result,
  input  logic                          m_we,
  input  rv_pkg::cycle_status_e         m_status,
  output logic                          w_we,
  output logic [rv_pkg::reg_addr_w-1:0] w_rd,
  output logic [rv_pkg::xlen-1:0]       w_data,
  output logic [rv_pkg::xlen-1:0]       trace_pc,
  output logic [31:0]                   trace_insn,
  output rv_pkg::cycle_status_e         trace_status,
  output logic                          trace_we,
  output logic [rv_pkg::reg_addr_w-1:0] trace_rd,
  output logic [rv_pkg::xlen-1:0]       trace_data
);

  rv_pkg::insn_u           w_word;
  logic [rv_pkg::xlen-1:0] w_pc;
  rv_pkg::cycle_status_e   w_status;

  // writeback register
  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc <= '0;
      w_word <= '0;
      w_data <= '0;
      w_we <= 1'b0;
      w_status <= rv_pkg::cycle_reset;
    end else begin
      w_pc <= m_pc;
      w_word <= m_insn;
      w_data <= m_result;
      w_we <= m_we;
      w_status <= m_status;
    end
  end

  assign w_rd = w_word.r_view.rd;

  // trace shows the retiring instruction and its register write
  assign trace_pc = w_pc;
  assign trace_insn = w_word;
  assign trace_status = w_status;
  assign trace_we = w_we;
  assign trace_rd = w_rd;
  assign trace_data = w_data;

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/100ps

module execute_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       x_pc,
  input  logic [31:0]                   x_insn,
  input  logic [rv_pkg::xlen-1:0]       x_a,
  input  logic [rv_pkg::xlen-1:0]       x_b,
  input  rv_pkg::cycle_status_e         x_status,
  input  logic                          w_we,
  input  logic [rv_pkg::reg_addr_w-1:0] w_rd,
  input  logic [rv_pkg::xlen-1:0]       w_data,
  output logic                          redirect,
  output logic [rv_pkg::xlen-1:0]       redirect_pc,
  output logic [rv_pkg::xlen-1:0]       m_pc,
  output logic [31:0]                   m_insn,
  output logic [rv_pkg::xlen-1:0]       m_result,
  output logic                          m_we,
  output rv_pkg::cycle_status_e         m_status
);

  rv_pkg::insn_u                   x_word;
  rv_pkg::insn_u                   m_word;
  logic [rv_pkg::reg_addr_w-1:0]   m_rd;
  logic [rv_pkg::xlen-1:0]         op_a;
  logic [rv_pkg::xlen-1:0]         op_b;
  logic [rv_pkg::xlen-1:0]         imm_i;
  logic [rv_pkg::xlen-1:0]         imm_b;
  logic                            is_lui;
  logic                            is_addi;
  logic                            is_add;
  logic                            is_bne;
  logic [rv_pkg::xlen-1:0]         result;
  logic                            we;

  assign x_word = x_insn;
  assign m_word = m_insn;
  assign m_rd = m_word.r_view.rd;

  // operand select, writeback first, then memory, then the decode value
  function automatic logic [rv_pkg::xlen-1:0] bypass(
    input logic [rv_pkg::reg_addr_w-1:0] rs,
    input logic [rv_pkg::xlen-1:0]       value
  );
    logic [rv_pkg::xlen-1:0] sel;
    sel = value;
    if (w_we && w_rd != '0 && w_rd == rs) begin
      sel = w_data;
    end else if (m_we && m_rd != '0 && m_rd == rs) begin
      sel = m_result;
    end
    return sel;
  endfunction

  always_comb begin
    op_a = bypass(x_word.r_view.rs1, x_a);
    op_b = bypass(x_word.r_view.rs2, x_b);
  end

  // i-type immediate sits where funct7 and rs2 are in the r-type view
  assign imm_i = {{(rv_pkg::xlen - 12){x_word.r_view.funct7[6]}},
                  x_word.r_view.funct7, x_word.r_view.rs2};
  assign imm_b = {{(rv_pkg::xlen - 13){x_word.b_view.imm_12}}, x_word.b_view.imm_12,
                  x_word.b_view.imm_11, x_word.b_view.imm_10_5, x_word.b_view.imm_4_1, 1'b0};

  assign is_lui = x_word.r_view.opcode == rv_pkg::opcode_lui;
  assign is_addi = x_word.r_view.opcode == rv_pkg::opcode_reg_imm &&
                   x_word.r_view.funct3 == rv_pkg::funct3_add;
  assign is_add = x_word.r_view.opcode == rv_pkg::opcode_reg_reg &&
                  x_word.r_view.funct3 == rv_pkg::funct3_add &&
                  x_word.r_view.funct7 == rv_pkg::funct7_base;
  assign is_bne = x_word.b_view.opcode == rv_pkg::opcode_branch &&
                  x_word.b_view.funct3 == rv_pkg::funct3_bne;

  // small alu, anything else leaves a zero result
  always_comb begin
    result = '0;
    if (is_lui) begin
      result = {x_insn[31:12], 12'd0};
    end else if (is_addi) begin
      result = op_a + imm_i;
    end else if (is_add) begin
      result = op_a + op_b;
    end
  end

  // only the three arithmetic ops write, and never to x0
  assign we = (is_lui || is_addi || is_add) && x_word.r_view.rd != '0;

  // bne resolves here, fetch and decode react on the next edge
  assign redirect = is_bne && (op_a != op_b);
  assign redirect_pc = x_pc + imm_b;

  // memory stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc <= '0;
      m_insn <= '0;
      m_result <= '0;
      m_we <= 1'b0;
      m_status <= rv_pkg::cycle_reset;
    end else begin
      m_pc <= x_pc;
      m_insn <= x_insn;
      m_result <= result;
      m_we <= we;
      m_status <= x_status;
    end
  end

endmodule

/* hdl/operand_decode.sv */
`timescale 1ns/100ps

module operand_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       d_pc,
  input  logic [31:0]                   d_insn,
  input  rv_pkg::cycle_status_e         d_status,
  input  logic                          redirect,
  input  logic                          w_we,
  input  logic [rv_pkg::reg_addr_w-1:0] w_rd,
  input  logic [rv_pkg::xlen-1:0]       w_data,
  output logic [rv_pkg::xlen-1:0]       x_pc,
  output logic [31:0]                   x_insn,
  output logic [rv_pkg::xlen-1:0]       x_a,
  output logic [rv_pkg::xlen-1:0]       x_b,
  output rv_pkg::cycle_status_e         x_status
);

  rv_pkg::insn_u           d_word;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] a_val;
  logic [rv_pkg::xlen-1:0] b_val;

  assign d_word = d_insn;

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (d_word.r_view.rs1),
    .rs2      (d_word.r_view.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (w_we),
    .rd       (w_rd),
    .rd_data  (w_data)
  );

  // WD bypass since the file is only written at the end of this cycle
  always_comb begin
    a_val = rs1_data;
    b_val = rs2_data;
    if (w_we && w_rd != '0 && w_rd == d_word.r_view.rs1) begin
      a_val = w_data;
    end
    if (w_we && w_rd != '0 && w_rd == d_word.r_view.rs2) begin
      b_val = w_data;
    end
  end

  // execute stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc <= '0;
      x_insn <= '0;
      x_a <= '0;
      x_b <= '0;
      x_status <= rv_pkg::cycle_reset;
    end else if (redirect) begin
      // the instruction in decode is on the wrong path
      x_pc <= '0;
      x_insn <= '0;
      x_a <= '0;
      x_b <= '0;
      x_status <= rv_pkg::cycle_taken_branch;
    end else begin
      x_pc <= d_pc;
      x_insn <= d_insn;
      x_a <= a_val;
      x_b <= b_val;
      x_status <= d_status;
    end
  end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [31:0]               insn_from_imem,
  input  logic                      redirect,
  input  logic [rv_pkg::xlen-1:0]   redirect_pc,
  output logic [rv_pkg::xlen-1:0]   pc_to_imem,
  output logic [rv_pkg::xlen-1:0]   d_pc,
  output logic [31:0]               d_insn,
  output rv_pkg::cycle_status_e     d_status
);

  logic [rv_pkg::xlen-1:0] pc;

  // sequential pc, a taken bne in execute wins
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else begin
      pc <= pc + rv_pkg::xlen'(4);
    end
  end

  // imem answers within the same cycle
  assign pc_to_imem = pc;

  // decode stage register, the word being fetched is dropped on a redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc <= '0;
      d_insn <= '0;
      d_status <= rv_pkg::cycle_reset;
    end else if (redirect) begin
      d_pc <= '0;
      d_insn <= '0;
      d_status <= rv_pkg::cycle_taken_branch;
    end else begin
      d_pc <= pc;
      d_insn <= insn_from_imem;
      d_status <= rv_pkg::cycle_no_stall;
    end
  end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]       rd_data
);

  localparam int num_regs = 2 ** rv_pkg::reg_addr_w;

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero on both asynchronous read ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

  // datapath and register index widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // major opcodes of the supported instructions
  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_reg_imm = 7'b0010011;
  localparam logic [6:0] opcode_reg_reg = 7'b0110011;
  localparam logic [6:0] opcode_branch = 7'b1100011;

  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [2:0] funct3_bne = 3'b001;

  // add uses an all-zero funct7, sub and friends do not
  localparam logic [6:0] funct7_base = 7'b0000000;

  // one instruction word, seen as an r-type or as a b-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_view;
  } insn_u;

  // what the writeback stage holds in a given cycle
  typedef enum logic [2:0] {
    cycle_reset = 3'd1,
    cycle_no_stall = 3'd2,
    cycle_taken_branch = 3'd4
  } cycle_status_e;

endpackage
